/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = video_gen_tb
FILELIST = video_gen.f
OBJ_DIR  = obj_dir
RUNARGS  = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/bitmap_fetch.sv */
// bitmap line fetch
module bitmap_fetch (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            fetch_window_i,
    input  logic            end_of_line_i,
    input  logic            end_of_frame_i,
    input  logic            pa_blank_i,
    input  vgen_pkg::addr_t pa_start_addr_i,
    input  vgen_pkg::addr_t pa_line_len_i,
    input  vgen_pkg::addr_t line_set_addr_i,
    input  logic            pa_line_addr_set_i,
    output logic            vram_sel_o,
    output vgen_pkg::addr_t vram_addr_o,
    output logic            word_valid_o
);
    import vgen_pkg::*;

    addr_t line_addr;           // start of current line
    addr_t word_idx;            // word within the line
    logic  odd_cycle;           // second half of a word slot
    logic  set_pending;         // line address written this line
    logic  use_set;

    always_comb begin
        vram_sel_o  = fetch_window_i && !pa_blank_i && !odd_cycle;
        vram_addr_o = line_addr + word_idx;
        use_set     = set_pending || pa_line_addr_set_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr    <= '0;
            word_idx     <= '0;
            odd_cycle    <= 1'b0;
            set_pending  <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= vram_sel_o;             // ram answers next cycle
            if (fetch_window_i) begin
                odd_cycle <= !odd_cycle;
                if (!odd_cycle) begin
                    word_idx <= word_idx + 1'b1;
                end
            end else begin
                odd_cycle <= 1'b0;
                word_idx  <= '0;
            end

            if (pa_line_addr_set_i) begin
                set_pending <= 1'b1;
            end
            if (end_of_line_i) begin
                set_pending <= 1'b0;
                // a written line address beats the frame reload
                if (use_set) begin
                    line_addr <= line_set_addr_i;
                end else if (end_of_frame_i) begin
                    line_addr <= pa_start_addr_i;
                end else begin
                    line_addr <= line_addr + pa_line_len_i;
                end
            end
        end
    end

endmodule

/* rtl/pixel_out.sv */
// pixel shifter and video output stage
module pixel_out #(
    parameter int H_OFFSCREEN = 16
) (
    input  logic              clk,
    input  logic              reset_i,
    input  vgen_pkg::word_t   vram_data_i,
    input  logic              word_valid_i,
    input  vgen_pkg::hcount_t h_count_i,
    input  logic              h_visible_i,
    input  logic              v_visible_i,
    input  logic              hsync_i,
    input  logic              vsync_i,
    input  vgen_pkg::color_t  border_color_i,
    input  vgen_pkg::color_t  pa_colorbase_i,
    input  logic              pa_blank_i,
    input  vgen_pkg::hcount_t vid_left_i,
    input  vgen_pkg::hcount_t vid_right_i,
    output vgen_pkg::color_t  color_index_o,
    output logic              dv_de_o,
    output logic              h_blank_o,
    output logic              v_blank_o,
    output logic              hsync_o,
    output logic              vsync_o
);
    import vgen_pkg::*;

    localparam hcount_t FIRST_COL   = hcount_t'(H_OFFSCREEN);
    localparam hcount_t FETCH_START = hcount_t'(H_OFFSCREEN - FETCH_LEAD);

    word_t  pix_shift;          // high byte is the current pixel
    logic   in_window;
    color_t pix_color;

    always_comb begin
        in_window = (h_count_i >= vid_left_i + FIRST_COL) &&
                    (h_count_i < vid_right_i + FIRST_COL);
        if (pa_blank_i || !in_window || !h_visible_i || !v_visible_i) begin
            pix_color = border_color_i;
        end else begin
            pix_color = pix_shift[15:8] ^ pa_colorbase_i;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid_i) begin
            pix_shift <= vram_data_i;
        end else if (h_count_i == FETCH_START) begin
            pix_shift <= '0;                        // drop leftovers from last line
        end else begin
            pix_shift <= {pix_shift[7:0], 8'h00};
        end
    end

    // common output register keeps sync, enable and color aligned
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
            dv_de_o       <= 1'b0;
            h_blank_o     <= 1'b1;
            v_blank_o     <= 1'b1;
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
        end else begin
            color_index_o <= pix_color;
            dv_de_o       <= h_visible_i && v_visible_i;
            h_blank_o     <= !h_visible_i;
            v_blank_o     <= !v_visible_i;
            hsync_o       <= hsync_i;
            vsync_o       <= vsync_i;
        end
    end

endmodule

/* rtl/vgen_pkg.sv */
// video generator shared types
package vgen_pkg;

    typedef logic [15:0] word_t;        // register and video ram data word
    typedef logic [15:0] addr_t;        // video ram word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [10:0] hcount_t;      // horizontal pixel counter
    typedef logic [9:0]  vcount_t;      // vertical line counter
    typedef logic [5:0]  reg_num_t;     // control register number

    // control register map
    localparam reg_num_t XR_VID_CTRL     = 6'h00;
    localparam reg_num_t XR_SCANLINE     = 6'h03;
    localparam reg_num_t XR_VID_LEFT     = 6'h04;
    localparam reg_num_t XR_VID_RIGHT    = 6'h05;
    localparam reg_num_t XR_PA_GFX_CTRL  = 6'h10;
    localparam reg_num_t XR_PA_DISP_ADDR = 6'h12;
    localparam reg_num_t XR_PA_LINE_LEN  = 6'h13;
    localparam reg_num_t XR_PA_LINE_ADDR = 6'h16;

    localparam color_t BORDER_RESET = 8'h08;    // dark grey border

    // one word of lead: read issued, data back, then shifter loaded
    localparam int FETCH_LEAD = 2;

endpackage

/* rtl/vgen_regs.sv */
// video control registers
module vgen_regs #(
    parameter int H_VISIBLE = 32
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               reg_wr_i,
    input  vgen_pkg::reg_num_t reg_num_i,
    input  vgen_pkg::word_t    reg_data_i,
    input  vgen_pkg::vcount_t  v_count_i,
    input  logic               end_of_visible_i,
    output vgen_pkg::word_t    reg_data_o,
    output logic               video_intr_o,
    output vgen_pkg::color_t   border_color_o,
    output vgen_pkg::color_t   pa_colorbase_o,
    output logic               pa_blank_o,
    output vgen_pkg::hcount_t  vid_left_o,
    output vgen_pkg::hcount_t  vid_right_o,
    output vgen_pkg::addr_t    pa_start_addr_o,
    output vgen_pkg::addr_t    pa_line_len_o,
    output vgen_pkg::addr_t    line_set_addr_o,
    output logic               pa_line_addr_set_o
);
    import vgen_pkg::*;

    word_t rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_intr_o       <= 1'b0;
            border_color_o     <= BORDER_RESET;
            pa_colorbase_o     <= '0;
            pa_blank_o         <= 1'b1;                     // playfield off until enabled
            vid_left_o         <= '0;
            vid_right_o        <= hcount_t'(H_VISIBLE);     // full width window
            pa_start_addr_o    <= '0;
            pa_line_len_o      <= addr_t'(H_VISIBLE / 2);   // two pixels per word
            line_set_addr_o    <= '0;
            pa_line_addr_set_o <= 1'b0;
        end else begin
            video_intr_o       <= end_of_visible_i;         // one pulse per frame
            pa_line_addr_set_o <= 1'b0;
            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        border_color_o <= reg_data_i[7:0];
                    end
                    XR_VID_LEFT: begin
                        vid_left_o <= hcount_t'(reg_data_i);
                    end
                    XR_VID_RIGHT: begin
                        vid_right_o <= hcount_t'(reg_data_i);
                    end
                    XR_PA_GFX_CTRL: begin
                        pa_colorbase_o <= reg_data_i[15:8];
                        pa_blank_o     <= reg_data_i[7];
                    end
                    XR_PA_DISP_ADDR: begin
                        pa_start_addr_o <= reg_data_i;
                    end
                    XR_PA_LINE_LEN: begin
                        pa_line_len_o <= reg_data_i;
                    end
                    XR_PA_LINE_ADDR: begin
                        line_set_addr_o    <= reg_data_i;
                        pa_line_addr_set_o <= 1'b1;         // applies at next line start
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read-back in the bit positions used for writes
    always_comb begin
        case (reg_num_i)
            XR_VID_CTRL:     rd_data = {8'h00, border_color_o};
            XR_SCANLINE:     rd_data = word_t'(v_count_i);
            XR_VID_LEFT:     rd_data = word_t'(vid_left_o);
            XR_VID_RIGHT:    rd_data = word_t'(vid_right_o);
            XR_PA_GFX_CTRL:  rd_data = {pa_colorbase_o, pa_blank_o, 7'b0};
            XR_PA_DISP_ADDR: rd_data = pa_start_addr_o;
            XR_PA_LINE_LEN:  rd_data = pa_line_len_o;
            XR_PA_LINE_ADDR: rd_data = line_set_addr_o;
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;              // one cycle after reg_num_i
    end

endmodule

/* rtl/vgen_timing.sv */
// raster timing generator
module vgen_timing #(
    parameter int H_TOTAL      = 48,
    parameter int H_OFFSCREEN  = 16,
    parameter int H_SYNC_START = 2,
    parameter int H_SYNC_WIDTH = 4,
    parameter int V_TOTAL      = 12,
    parameter int V_VISIBLE    = 8,
    parameter int V_SYNC_START = 9,
    parameter int V_SYNC_WIDTH = 1
) (
    input  logic              clk,
    input  logic              reset_i,
    output vgen_pkg::hcount_t h_count_o,
    output vgen_pkg::vcount_t v_count_o,
    output logic              h_visible_o,
    output logic              v_visible_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              end_of_line_o,
    output logic              end_of_frame_o,
    output logic              end_of_visible_o,
    output logic              fetch_window_o
);
    import vgen_pkg::*;

    localparam hcount_t H_LAST      = hcount_t'(H_TOTAL - 1);
    localparam hcount_t H_FIRST_VIS = hcount_t'(H_OFFSCREEN);
    localparam hcount_t H_FETCH     = hcount_t'(H_OFFSCREEN - FETCH_LEAD);
    localparam hcount_t H_HS_BEGIN  = hcount_t'(H_SYNC_START);
    localparam hcount_t H_HS_END    = hcount_t'(H_SYNC_START + H_SYNC_WIDTH);
    localparam vcount_t V_LAST      = vcount_t'(V_TOTAL - 1);
    localparam vcount_t V_LAST_VIS  = vcount_t'(V_VISIBLE - 1);
    localparam vcount_t V_VS_BEGIN  = vcount_t'(V_SYNC_START);
    localparam vcount_t V_VS_END    = vcount_t'(V_SYNC_START + V_SYNC_WIDTH);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else if (end_of_line_o) begin
            h_count_o <= '0;
            v_count_o <= (v_count_o == V_LAST) ? '0 : v_count_o + 1'b1;    // wrap at frame end
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end

    always_comb begin
        h_visible_o      = (h_count_o >= H_FIRST_VIS);
        v_visible_o      = (v_count_o <= V_LAST_VIS);
        hsync_o          = (h_count_o >= H_HS_BEGIN) && (h_count_o < H_HS_END);
        vsync_o          = (v_count_o >= V_VS_BEGIN) && (v_count_o < V_VS_END);
        end_of_line_o    = (h_count_o == H_LAST);
        end_of_frame_o   = end_of_line_o && (v_count_o == V_LAST);
        end_of_visible_o = end_of_line_o && (v_count_o == V_LAST_VIS);
        fetch_window_o   = (h_count_o >= H_FETCH) && v_visible_o;   // runs to end of line
    end

endmodule

/* rtl/video_gen.sv */
// bitmap video generator top
module video_gen #(
    parameter int H_TOTAL      = 48,
    parameter int H_OFFSCREEN  = 16,
    parameter int H_SYNC_START = 2,
    parameter int H_SYNC_WIDTH = 4,
    parameter int V_TOTAL      = 12,
    parameter int V_VISIBLE    = 8,
    parameter int V_SYNC_START = 9,
    parameter int V_SYNC_WIDTH = 1
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               reg_wr_i,
    input  vgen_pkg::reg_num_t reg_num_i,
    input  vgen_pkg::word_t    reg_data_i,
    output vgen_pkg::word_t    reg_data_o,
    output logic               video_intr_o,
    output logic               vram_sel_o,
    output vgen_pkg::addr_t    vram_addr_o,
    input  vgen_pkg::word_t    vram_data_i,
    output vgen_pkg::color_t   color_index_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o,
    output logic               h_blank_o,
    output logic               v_blank_o
);
    import vgen_pkg::*;

    localparam int H_VISIBLE = H_TOTAL - H_OFFSCREEN;

    hcount_t h_count;
    vcount_t v_count;
    logic    h_visible;
    logic    v_visible;
    logic    hsync;
    logic    vsync;
    logic    end_of_line;
    logic    end_of_frame;
    logic    end_of_visible;
    logic    fetch_window;
    color_t  border_color;
    color_t  pa_colorbase;
    logic    pa_blank;
    hcount_t vid_left;
    hcount_t vid_right;
    addr_t   pa_start_addr;
    addr_t   pa_line_len;
    addr_t   line_set_addr;
    logic    pa_line_addr_set;
    logic    word_valid;

    vgen_timing #(
        .H_TOTAL(H_TOTAL),
        .H_OFFSCREEN(H_OFFSCREEN),
        .H_SYNC_START(H_SYNC_START),
        .H_SYNC_WIDTH(H_SYNC_WIDTH),
        .V_TOTAL(V_TOTAL),
        .V_VISIBLE(V_VISIBLE),
        .V_SYNC_START(V_SYNC_START),
        .V_SYNC_WIDTH(V_SYNC_WIDTH)
    ) u_timing (
        .clk(clk),
        .reset_i(reset_i),
        .h_count_o(h_count),
        .v_count_o(v_count),
        .h_visible_o(h_visible),
        .v_visible_o(v_visible),
        .hsync_o(hsync),
        .vsync_o(vsync),
        .end_of_line_o(end_of_line),
        .end_of_frame_o(end_of_frame),
        .end_of_visible_o(end_of_visible),
        .fetch_window_o(fetch_window)
    );

    vgen_regs #(
        .H_VISIBLE(H_VISIBLE)
    ) u_regs (
        .clk(clk),
        .reset_i(reset_i),
        .reg_wr_i(reg_wr_i),
        .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i),
        .v_count_i(v_count),
        .end_of_visible_i(end_of_visible),
        .reg_data_o(reg_data_o),
        .video_intr_o(video_intr_o),
        .border_color_o(border_color),
        .pa_colorbase_o(pa_colorbase),
        .pa_blank_o(pa_blank),
        .vid_left_o(vid_left),
        .vid_right_o(vid_right),
        .pa_start_addr_o(pa_start_addr),
        .pa_line_len_o(pa_line_len),
        .line_set_addr_o(line_set_addr),
        .pa_line_addr_set_o(pa_line_addr_set)
    );

    bitmap_fetch u_fetch (
        .clk(clk),
        .reset_i(reset_i),
        .fetch_window_i(fetch_window),
        .end_of_line_i(end_of_line),
        .end_of_frame_i(end_of_frame),
        .pa_blank_i(pa_blank),
        .pa_start_addr_i(pa_start_addr),
        .pa_line_len_i(pa_line_len),
        .line_set_addr_i(line_set_addr),
        .pa_line_addr_set_i(pa_line_addr_set),
        .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o),
        .word_valid_o(word_valid)
    );

    pixel_out #(
        .H_OFFSCREEN(H_OFFSCREEN)
    ) u_pixel (
        .clk(clk),
        .reset_i(reset_i),
        .vram_data_i(vram_data_i),
        .word_valid_i(word_valid),
        .h_count_i(h_count),
        .h_visible_i(h_visible),
        .v_visible_i(v_visible),
        .hsync_i(hsync),
        .vsync_i(vsync),
        .border_color_i(border_color),
        .pa_colorbase_i(pa_colorbase),
        .pa_blank_i(pa_blank),
        .vid_left_i(vid_left),
        .vid_right_i(vid_right),
        .color_index_o(color_index_o),
        .dv_de_o(dv_de_o),
        .h_blank_o(h_blank_o),
        .v_blank_o(v_blank_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o)
    );

endmodule

/* tb/video_gen_sva.sv */
// video generator assertions
module video_gen_sva #(
    parameter int H_TOTAL      = 48,
    parameter int H_OFFSCREEN  = 16,
    parameter int H_SYNC_START = 2,
    parameter int H_SYNC_WIDTH = 4,
    parameter int V_TOTAL      = 12,
    parameter int V_VISIBLE    = 8,
    parameter int V_SYNC_START = 9,
    parameter int V_SYNC_WIDTH = 1
) (
    input logic               clk,
    input logic               reset_i,
    input logic               reg_wr_i,
    input vgen_pkg::reg_num_t reg_num_i,
    input vgen_pkg::word_t    reg_data_i,
    input vgen_pkg::word_t    reg_data_o,
    input logic               video_intr_o,
    input logic               vram_sel_o,
    input vgen_pkg::addr_t    vram_addr_o,
    input vgen_pkg::color_t   color_index_o,
    input logic               hsync_o,
    input logic               vsync_o,
    input logic               dv_de_o,
    input logic               h_blank_o,
    input logic               v_blank_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import vgen_pkg::*;

    localparam int H_VISIBLE   = H_TOTAL - H_OFFSCREEN;
    localparam int FETCH_START = H_OFFSCREEN - 2;   // reads lead the first column by one word

    int      sva_errors = 0;
    int      hm;                // expected beam position
    int      vm;
    int      col;
    logic    out_ok;            // outputs reflect a counted cycle
    color_t  border_m;
    color_t  base_m;
    logic    blank_m;
    hcount_t left_m;
    hcount_t right_m;
    addr_t   start_m;
    addr_t   len_m;
    addr_t   line_m;            // first word of the current line
    addr_t   set_m;
    logic    pend_m;            // line address write waiting for line end
    addr_t   pix_addr;
    addr_t   fetch_addr;
    logic    fetch_exp;
    word_t   rd_now;
    word_t   rd_exp;
    color_t  pix_now;
    color_t  pix_exp;
    logic    hs_exp;
    logic    vs_exp;
    logic    de_exp;
    logic    hb_exp;
    logic    vb_exp;
    logic    intr_exp;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hm       <= 0;
            vm       <= 0;
            out_ok   <= 1'b0;
            border_m <= BORDER_RESET;
            base_m   <= '0;
            blank_m  <= 1'b1;
            left_m   <= '0;
            right_m  <= hcount_t'(H_VISIBLE);
            start_m  <= '0;
            len_m    <= addr_t'(H_VISIBLE / 2);
            line_m   <= '0;
            set_m    <= '0;
            pend_m   <= 1'b0;
        end else begin
            out_ok <= 1'b1;
            if (hm == H_TOTAL - 1) begin
                hm     <= 0;
                vm     <= (vm == V_TOTAL - 1) ? 0 : vm + 1;
                pend_m <= 1'b0;
                if (pend_m) begin
                    line_m <= set_m;
                end else if (vm == V_TOTAL - 1) begin
                    line_m <= start_m;          // new frame
                end else begin
                    line_m <= line_m + len_m;
                end
            end else begin
                hm <= hm + 1;
            end
            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL:     border_m <= reg_data_i[7:0];
                    XR_VID_LEFT:     left_m <= reg_data_i[10:0];
                    XR_VID_RIGHT:    right_m <= reg_data_i[10:0];
                    XR_PA_DISP_ADDR: start_m <= reg_data_i;
                    XR_PA_LINE_LEN:  len_m <= reg_data_i;
                    XR_PA_GFX_CTRL: begin
                        base_m  <= reg_data_i[15:8];
                        blank_m <= reg_data_i[7];
                    end
                    XR_PA_LINE_ADDR: begin
                        set_m  <= reg_data_i;
                        pend_m <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        col        = hm - H_OFFSCREEN;
        pix_addr   = line_m + addr_t'(col / 2);
        fetch_addr = line_m + addr_t'((hm - FETCH_START) / 2);
        fetch_exp  = !blank_m && (vm < V_VISIBLE) && (hm >= FETCH_START) &&
                     ((hm - FETCH_START) % 2 == 0);
        if (blank_m || col < 0 || vm >= V_VISIBLE || col < int'(left_m) ||
            col >= int'(right_m)) begin
            pix_now = border_m;
        end else if (col % 2 == 0) begin
            pix_now = pix_addr[7:0] ^ base_m;       // memory high byte
        end else begin
            pix_now = ~pix_addr[7:0] ^ base_m;
        end
        case (reg_num_i)
            XR_VID_CTRL:     rd_now = {8'h00, border_m};
            XR_SCANLINE:     rd_now = word_t'(vm);
            XR_VID_LEFT:     rd_now = word_t'(left_m);
            XR_VID_RIGHT:    rd_now = word_t'(right_m);
            XR_PA_GFX_CTRL:  rd_now = {base_m, blank_m, 7'h00};
            XR_PA_DISP_ADDR: rd_now = start_m;
            XR_PA_LINE_LEN:  rd_now = len_m;
            XR_PA_LINE_ADDR: rd_now = set_m;
            default:         rd_now = '0;
        endcase
    end

    // outputs lag the beam by one register stage
    always_ff @(posedge clk) begin
        rd_exp   <= rd_now;
        pix_exp  <= pix_now;
        hs_exp   <= (hm >= H_SYNC_START) && (hm < H_SYNC_START + H_SYNC_WIDTH);
        vs_exp   <= (vm >= V_SYNC_START) && (vm < V_SYNC_START + V_SYNC_WIDTH);
        de_exp   <= (hm >= H_OFFSCREEN) && (vm < V_VISIBLE);
        hb_exp   <= (hm < H_OFFSCREEN);
        vb_exp   <= (vm >= V_VISIBLE);
        intr_exp <= (hm == H_TOTAL - 1) && (vm == V_VISIBLE - 1);
    end

    a_read: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> reg_data_o == rd_exp)
        else begin
            sva_errors++;
            $error("Mismatch reg_data_o: got %h expected %h", $sampled(reg_data_o),
                   $sampled(rd_exp));
        end

    a_hsync: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> hsync_o == hs_exp)
        else begin
            sva_errors++;
            $error("Mismatch hsync_o: got %h expected %h", $sampled(hsync_o),
                   $sampled(hs_exp));
        end

    a_vsync: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> vsync_o == vs_exp)
        else begin
            sva_errors++;
            $error("Mismatch vsync_o: got %h expected %h", $sampled(vsync_o),
                   $sampled(vs_exp));
        end

    a_de: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> dv_de_o == de_exp)
        else begin
            sva_errors++;
            $error("Mismatch dv_de_o: got %h expected %h", $sampled(dv_de_o),
                   $sampled(de_exp));
        end

    a_hblank: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> h_blank_o == hb_exp)
        else begin
            sva_errors++;
            $error("Mismatch h_blank_o: got %h expected %h", $sampled(h_blank_o),
                   $sampled(hb_exp));
        end

    a_vblank: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> v_blank_o == vb_exp)
        else begin
            sva_errors++;
            $error("Mismatch v_blank_o: got %h expected %h", $sampled(v_blank_o),
                   $sampled(vb_exp));
        end

    a_intr: assert property (@(posedge clk) disable iff (reset_i)
        out_ok |-> video_intr_o == intr_exp)
        else begin
            sva_errors++;
            $error("Mismatch video_intr_o: got %h expected %h", $sampled(video_intr_o),
                   $sampled(intr_exp));
        end

    a_sel: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o == fetch_exp)
        else begin
            sva_errors++;
            $error("Mismatch vram_sel_o: got %h expected %h", $sampled(vram_sel_o),
                   $sampled(fetch_exp));
        end

    a_addr: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> vram_addr_o == fetch_addr)
        else begin
            sva_errors++;
            $error("Mismatch vram_addr_o: got %h expected %h", $sampled(vram_addr_o),
                   $sampled(fetch_addr));
        end

    a_pixel: assert property (@(posedge clk) disable iff (reset_i)
        (out_ok && dv_de_o) |-> color_index_o == pix_exp)
        else begin
            sva_errors++;
            $error("Mismatch color_index_o: got %h expected %h", $sampled(color_index_o),
                   $sampled(pix_exp));
        end

endmodule

bind video_gen video_gen_sva #(
    .H_TOTAL(H_TOTAL),
    .H_OFFSCREEN(H_OFFSCREEN),
    .H_SYNC_START(H_SYNC_START),
    .H_SYNC_WIDTH(H_SYNC_WIDTH),
    .V_TOTAL(V_TOTAL),
    .V_VISIBLE(V_VISIBLE),
    .V_SYNC_START(V_SYNC_START),
    .V_SYNC_WIDTH(V_SYNC_WIDTH)
) u_sva (
    .clk(clk),
    .reset_i(reset_i),
    .reg_wr_i(reg_wr_i),
    .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i),
    .reg_data_o(reg_data_o),
    .video_intr_o(video_intr_o),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o),
    .color_index_o(color_index_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .dv_de_o(dv_de_o),
    .h_blank_o(h_blank_o),
    .v_blank_o(v_blank_o)
);

/* tb/video_gen_tb.sv */
// video generator testbench
module video_gen_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vgen_pkg::*;

    localparam int CYCLE_LIMIT = 4000;      // three 576-cycle frames plus margin
    localparam int FRAMES_RUN  = 3;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        reg_wr_i;
    reg_num_t    reg_num_i;
    word_t       reg_data_i;
    word_t       reg_data_o;
    logic        video_intr_o;
    logic        vram_sel_o;
    addr_t       vram_addr_o;
    word_t       vram_data_i;
    color_t      color_index_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;
    logic        h_blank_o;
    logic        v_blank_o;
    int          seed = 32'hd409cc5b;
    logic [31:0] rnd;
    int          cycles = 0;
    int          intr_count = 0;
    int          tb_errors = 0;
    logic        req_sel = 1'b0;    // read issued last cycle
    addr_t       req_addr = '0;

    video_gen u_dut (
        .clk(clk),
        .reset_i(reset_i),
        .reg_wr_i(reg_wr_i),
        .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i),
        .reg_data_o(reg_data_o),
        .video_intr_o(video_intr_o),
        .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o),
        .vram_data_i(vram_data_i),
        .color_index_o(color_index_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o),
        .h_blank_o(h_blank_o),
        .v_blank_o(v_blank_o)
    );

    always #4 clk = ~clk;

    // video ram contents: address low byte, then its inverse
    function automatic word_t ram_word(input addr_t addr);
        return {addr[7:0], ~addr[7:0]};
    endfunction

    always @(posedge clk) begin
        #1;
        if (req_sel) begin
            vram_data_i = ram_word(req_addr);       // answer one cycle after select
        end
        req_sel  = vram_sel_o;
        req_addr = vram_addr_o;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (video_intr_o === 1'b1) begin
            intr_count++;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input reg_num_t num, input word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        next_cycle();
        reg_wr_i = 1'b0;
    endtask

    // read data is compared by the bound assertions one cycle later
    task automatic read_reg(input reg_num_t num);
        reg_num_i = num;
        next_cycle();
    endtask

    task automatic wait_frame();
        do next_cycle(); while (video_intr_o !== 1'b1);
    endtask

    task automatic wait_line_end();
        do next_cycle(); while (dv_de_o !== 1'b1);
        do next_cycle(); while (dv_de_o !== 1'b0);
    endtask

    initial begin
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = XR_VID_CTRL;
        reg_data_i  = '0;
        vram_data_i = '0;
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;

        read_reg(XR_VID_CTRL);      // reset values
        read_reg(XR_VID_LEFT);
        read_reg(XR_VID_RIGHT);
        read_reg(XR_PA_LINE_LEN);
        read_reg(XR_SCANLINE);
        read_reg(6'h3f);            // unmapped

        rnd = $random(seed);
        write_reg(XR_VID_CTRL, rnd[31:16]);
        read_reg(XR_VID_CTRL);
        write_reg(XR_PA_GFX_CTRL, {rnd[15:8], 1'b1, 7'h00});   // still blanked
        read_reg(XR_PA_GFX_CTRL);
        rnd = $random(seed);
        write_reg(XR_PA_DISP_ADDR, rnd[15:0]);
        read_reg(XR_PA_DISP_ADDR);
        write_reg(XR_PA_LINE_LEN, {8'h00, rnd[23:16]});
        read_reg(XR_PA_LINE_LEN);
        write_reg(XR_VID_LEFT, word_t'(rnd[26:24]));
        read_reg(XR_VID_LEFT);
        write_reg(XR_VID_RIGHT, 16'd24 + word_t'(rnd[29:27]));
        read_reg(XR_VID_RIGHT);
        reg_num_i = XR_SCANLINE;

        wait_frame();
        rnd = $random(seed);
        write_reg(XR_PA_GFX_CTRL, {rnd[7:0], 8'h00});           // playfield on
        reg_num_i = XR_SCANLINE;
        wait_frame();

        // mid-frame changes in the third frame
        wait_line_end();
        rnd = $random(seed);
        write_reg(XR_PA_LINE_ADDR, rnd[15:0]);
        write_reg(XR_PA_GFX_CTRL, {rnd[23:16], 8'h00});
        write_reg(XR_VID_LEFT, 16'd2);
        write_reg(XR_VID_RIGHT, 16'd20);
        reg_num_i = XR_SCANLINE;
        wait_line_end();
        write_reg(XR_PA_GFX_CTRL, {rnd[31:24], 8'h80});         // one blanked line
        wait_line_end();
        write_reg(XR_PA_GFX_CTRL, {rnd[31:24], 8'h00});
        reg_num_i = XR_SCANLINE;
        wait_frame();
        read_reg(XR_PA_LINE_ADDR);
        read_reg(XR_PA_GFX_CTRL);
        read_reg(XR_SCANLINE);
        next_cycle();

        if (intr_count != FRAMES_RUN) begin
            tb_errors++;
            $display("Mismatch intr_count: got %h expected %h", intr_count, FRAMES_RUN);
        end
        $display("Errors: %0d assertion, %0d testbench", u_dut.u_sva.sva_errors, tb_errors);
        if (u_dut.u_sva.sva_errors == 0 && tb_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* video_gen.f */
rtl/vgen_pkg.sv
rtl/vgen_timing.sv
rtl/vgen_regs.sv
rtl/bitmap_fetch.sv
rtl/pixel_out.sv
rtl/video_gen.sv
tb/video_gen_sva.sv
tb/video_gen_tb.sv
